//--- Makefile
# Verilator simulation of the SoC memory-mapped core

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_soc_top
FILELIST  = list.f

.PHONY: sim clean

# build, run, and pass only if the testbench reports success
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- bench/soc_cases.txt
// columns: we addr wdata be chk exp_rdata exp_err, all hex
// chk 0 skips the rdata compare, err is always compared
1 00010000 1122334455667788 ff 1 0000000000000000 0
1 00010008 a5a5a5a5a5a5a5a5 ff 1 0000000000000000 0
0 00010000 0000000000000000 00 1 1122334455667788 0
1 00010000 ffeeddccbbaa9988 0f 1 0000000000000000 0
0 00010000 0000000000000000 00 1 11223344bbaa9988 0
1 00010008 0000000000003c00 02 1 0000000000000000 0
0 00010008 0000000000000000 00 1 a5a5a5a5a5a53ca5 0
1 00010008 5a00000000000000 80 1 0000000000000000 0
0 00010008 0000000000000000 00 1 5aa5a5a5a5a53ca5 0
1 00011000 deadbeefdeadbeef ff 1 0000000000000000 1
0 00011000 0000000000000000 00 1 0000000000000000 1
1 00000000 deadbeefdeadbeef ff 1 0000000000000000 1
1 020c0000 0000000000000001 ff 1 0000000000000000 1
1 12000000 0000000000000001 ff 1 0000000000000000 1
0 00010000 0000000000000000 00 1 11223344bbaa9988 0
0 02000000 0000000000000000 00 1 0000000000000000 0
0 02004000 0000000000000000 00 1 ffffffffffffffff 0
0 02000100 0000000000000000 00 1 0000000000000000 0
0 0200bff8 0000000000000000 00 0 0000000000000000 0
0 fffffff8 0000000000000000 00 1 0000000000000000 1
0 00010ff8 0000000000000000 00 0 0000000000000000 0

//--- bench/tb_soc_top.sv
// Testbench for the SoC memory-mapped core. Replays the access list in
// bench/soc_cases.txt as one back-to-back burst, then runs boot RAM
// fills and the CLINT timer and software interrupt sequences.
// Run from the project root through the Makefile.

`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;

  localparam int unsigned RomWords   = 512;
  localparam int unsigned MaxCases   = 64;
  localparam int unsigned CaseCols   = 7;
  localparam int unsigned RspTimeout = 10;
  localparam int unsigned NumFills   = 16;
  localparam soc_pkg::addr_t MsipAddr     = soc_pkg::ClintBase + soc_pkg::MsipOffset;
  localparam soc_pkg::addr_t MtimecmpAddr = soc_pkg::ClintBase + soc_pkg::MtimecmpOffset;
  localparam soc_pkg::addr_t MtimeAddr    = soc_pkg::ClintBase + soc_pkg::MtimeOffset;
  localparam soc_pkg::data_t MtimeStart   = 64'h0000_0000_0000_1000;

  typedef struct packed {
    logic           chk;   // compare rdata
    soc_pkg::data_t rdata;
    logic           err;
    logic [31:0]    cyc;   // cycle the response is due
  } expect_t;

  logic              clk;
  logic              ndmreset_n;
  logic              req_i;
  soc_pkg::bus_req_t req_data_i;
  logic              rsp_valid_o;
  soc_pkg::bus_rsp_t rsp_o;
  logic              timer_irq_o;
  logic              ipi_o;

  logic [31:0]    cycle;
  int unsigned    errors;
  int unsigned    checks;
  int unsigned    req_count;
  int unsigned    rsp_count;
  expect_t        exp_q[$];
  soc_pkg::data_t last_rdata;
  logic [63:0]    case_mem [CaseCols*MaxCases];
  soc_pkg::data_t fill_model [int unsigned];
  event           timeout_ev;

  soc_top #(
    .RomWords ( RomWords )
  ) dut_i (
    .clk         ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( req_i       ),
    .req_data_i  ( req_data_i  ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  task automatic compare(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_and_finish();
    $display("checks %0d, errors %0d, requests %0d, responses %0d",
             checks, errors, req_count, rsp_count);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
    -> timeout_ev;
    forever @(posedge clk); // main sequence stops here
  endtask

  initial begin
    @(timeout_ev);
    report_and_finish();
  end

  // ------------------------------
  // response monitor
  // ------------------------------
  always @(negedge clk) begin : monitor_rsp
    expect_t e;
    if (ndmreset_n && rsp_valid_o) begin
      rsp_count++;
      last_rdata = rsp_o.rdata;
      if (exp_q.size() == 0) begin
        errors++;
        $display("response at %0t arrived with no request outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        compare("rsp_valid_o cycle", cycle, e.cyc);
        compare("rsp_o.err", rsp_o.err, e.err);
        if (e.chk) compare("rsp_o.rdata", rsp_o.rdata, e.rdata);
      end
    end
  end

  // called 1 ns after an edge, leaves req_i high for bursts
  task automatic issue(input logic we, input soc_pkg::addr_t addr, input soc_pkg::data_t wdata,
                       input soc_pkg::be_t be, input logic chk,
                       input soc_pkg::data_t exp_rdata, input logic exp_err);
    expect_t e;
    req_i            = 1'b1;
    req_data_i.we    = we;
    req_data_i.addr  = addr;
    req_data_i.wdata = wdata;
    req_data_i.be    = be;
    e.chk   = chk;
    e.rdata = exp_rdata;
    e.err   = exp_err;
    e.cyc   = cycle + 1;
    exp_q.push_back(e);
    req_count++;
    @(posedge clk);
    #1;
  endtask

  task automatic write_word(input soc_pkg::addr_t addr, input soc_pkg::data_t wdata);
    issue(1'b1, addr, wdata, '1, 1'b1, '0, 1'b0);
  endtask

  task automatic wait_responses(input string what);
    int unsigned waited;
    waited = 0;
    req_i  = 1'b0;
    while (exp_q.size() != 0 && waited < RspTimeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) abort_on_timeout(what);
  endtask

  task automatic wait_for_level(input string name, input bit timer, input logic level,
                                input int unsigned limit);
    int unsigned waited;
    logic        cur;
    waited = 0;
    req_i  = 1'b0;
    cur    = timer ? timer_irq_o : ipi_o;
    while (cur !== level && waited < limit) begin
      @(posedge clk);
      #1;
      waited++;
      cur = timer ? timer_irq_o : ipi_o;
    end
    if (cur !== level) abort_on_timeout(name);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int unsigned    ncases;
    int unsigned    b;
    int unsigned    idx;
    logic [31:0]    wr_cyc;
    logic [31:0]    rd_cyc;
    soc_pkg::data_t wdata;
    soc_pkg::data_t mtime;
    soc_pkg::data_t hi;
    void'($urandom(32'h15de9329));
    cycle      = '0;
    errors     = 0;
    checks     = 0;
    req_count  = 0;
    rsp_count  = 0;
    ndmreset_n = 1'b0;
    req_i      = 1'b0;
    req_data_i = '0;
    for (int i = 0; i < CaseCols*MaxCases; i++) case_mem[i] = '1; // end marker
    $readmemh("bench/soc_cases.txt", case_mem);
    repeat (5) @(posedge clk);
    #1 ndmreset_n = 1'b1;
    @(posedge clk);
    #1;
    compare("rsp_valid_o", rsp_valid_o, 1'b0);
    compare("timer_irq_o", timer_irq_o, 1'b0);
    compare("ipi_o", ipi_o, 1'b0);

    // case file as one burst
    ncases = 0;
    while (ncases < MaxCases && case_mem[CaseCols*ncases] <= 1) ncases++;
    if (ncases == 0) begin
      errors++;
      $display("the case file bench/soc_cases.txt holds no usable access");
    end
    for (int n = 0; n < ncases; n++) begin
      b = CaseCols * n;
      issue(case_mem[b][0], case_mem[b+1][31:0], case_mem[b+2], case_mem[b+3][7:0],
            case_mem[b+4][0], case_mem[b+5], case_mem[b+6][0]);
    end
    wait_responses("responses to the case file burst");

    // random full-word fills, distinct indices
    while (fill_model.num() < NumFills) begin
      idx = $urandom_range(RomWords - 1, 0);
      if (!fill_model.exists(idx)) begin
        wdata = {$urandom, $urandom};
        fill_model[idx] = wdata;
        write_word(soc_pkg::RomBase + soc_pkg::addr_t'(idx * 8), wdata);
      end
    end
    foreach (fill_model[i]) begin
      issue(1'b0, soc_pkg::RomBase + soc_pkg::addr_t'(i * 8), '0, '0, 1'b1, fill_model[i], 1'b0);
    end
    wait_responses("responses to the boot RAM fill");

    // ------------------------------
    // timer interrupt
    // ------------------------------
    wr_cyc = cycle;
    write_word(MtimeAddr, MtimeStart);
    write_word(MtimecmpAddr, MtimeStart + 64'h1_0000_0000);
    wait_responses("responses to the timer setup");
    repeat (4) @(posedge clk);
    #1;
    compare("timer_irq_o", timer_irq_o, 1'b0);
    write_word(MtimecmpAddr, MtimeStart);
    wait_for_level("timer_irq_o to rise", 1'b1, 1'b1, 3);
    wait_responses("response to the mtimecmp write");
    rd_cyc = cycle;
    issue(1'b0, MtimeAddr, '0, '0, 1'b0, '0, 1'b0);
    wait_responses("response to the mtime read");
    mtime = last_rdata;
    hi    = MtimeStart + soc_pkg::data_t'((rd_cyc - wr_cyc) / 2) + 1;
    // mtime lies between the written value and one tick per two cycles
    if (mtime < MtimeStart) compare("mtime", mtime, MtimeStart);
    if (mtime > hi) compare("mtime", mtime, hi);

    // ------------------------------
    // software interrupt
    // ------------------------------
    write_word(MsipAddr, 64'h1);
    wait_for_level("ipi_o to rise", 1'b0, 1'b1, 3);
    issue(1'b0, MsipAddr, '0, '0, 1'b1, 64'h1, 1'b0);
    issue(1'b0, soc_pkg::ClintBase + 32'h8000, '0, '0, 1'b1, '0, 1'b0); // unused offset
    write_word(MsipAddr, 64'h0);
    wait_for_level("ipi_o to fall", 1'b0, 1'b0, 3);
    wait_responses("responses to the msip accesses");

    compare("response count", rsp_count, req_count);
    report_and_finish();
  end

endmodule

`default_nettype wire

//--- hw/address_decoder.sv
// Decode stage. Matches the request address against the SoC map and
// raises the strobe of the one target that owns it. An address that
// hits no region leaves region_sel_o at zero for the result stage.

`timescale 1ns/1ps
`default_nettype none

module address_decoder #(
  parameter int unsigned RomWords = 512
) (
  input  logic                 req_i,
  input  soc_pkg::addr_t       addr_i,
  output logic                 ram_req_o,
  output logic                 clint_req_o,
  output soc_pkg::region_sel_t region_sel_o
);

  // inclusive region ends
  localparam soc_pkg::addr_t RomLast =
    soc_pkg::RomBase + soc_pkg::addr_t'(RomWords * soc_pkg::BeWidth) - 1;
  localparam soc_pkg::addr_t ClintLast =
    soc_pkg::ClintBase + soc_pkg::ClintLength - 1;

  logic ram_hit;
  logic clint_hit;

  assign ram_hit   = (addr_i >= soc_pkg::RomBase) && (addr_i <= RomLast);
  assign clint_hit = (addr_i >= soc_pkg::ClintBase) && (addr_i <= ClintLast);

  assign region_sel_o = {clint_hit, ram_hit};

  // ------------------------------
  // target strobes
  // ------------------------------
  assign ram_req_o   = req_i & region_sel_o[0];
  assign clint_req_o = req_i & region_sel_o[1];

  // a RomWords that grows the RAM into the CLINT window would break this
  always_comb begin
    if (req_i) begin
      assert ($onehot0(region_sel_o))
        else $error("address %h decodes to more than one region", addr_i);
    end
  end

endmodule

`default_nettype wire

//--- hw/boot_ram.sv
// Boot RAM behind the strobe bus. Word addressed with byte enables,
// one access per cycle, read data registered on the request edge.
// Writes register zero so the result stage can pass rdata straight on.

`timescale 1ns/1ps
`default_nettype none

module boot_ram #(
  parameter int unsigned RomWords = 512
) (
  input  logic              clk,
  input  logic              req_i,
  input  soc_pkg::bus_req_t req_data_i,
  output soc_pkg::data_t    rdata_o
);

  localparam int unsigned IdxWidth = $clog2(RomWords);
  localparam int unsigned OffWidth = $clog2(soc_pkg::BeWidth);

  soc_pkg::data_t mem [RomWords];

  logic [IdxWidth-1:0] idx;

  // byte offset dropped, upper bits wrap modulo RomWords
  assign idx = req_data_i.addr[OffWidth +: IdxWidth];

  // ------------------------------
  // array port
  // ------------------------------
  always_ff @(posedge clk) begin
    if (req_i) begin
      if (req_data_i.we) begin
        mem[idx] <= soc_pkg::be_merge(mem[idx], req_data_i.wdata, req_data_i.be);
        rdata_o  <= '0;
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/clint.sv
// Core-local interruptor. Holds msip, mtimecmp and mtime for a single
// hart. mtime counts on a real-time tick made by halving clk.
// timer_irq_o and ipi_o go straight to the hart's interrupt inputs.
// Read data is registered on the request edge like the boot RAM.

`timescale 1ns/1ps
`default_nettype none

module clint (
  input  logic              clk,
  input  logic              ndmreset_n,
  input  logic              req_i,
  input  soc_pkg::bus_req_t req_data_i,
  output soc_pkg::data_t    rdata_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  // offsets are compared per 64-bit word
  localparam soc_pkg::addr_t WordMask = ~soc_pkg::addr_t'(soc_pkg::BeWidth - 1);

  logic           rtc_q;
  soc_pkg::data_t mtime_q;
  soc_pkg::data_t mtimecmp_q;
  logic           msip_q;

  soc_pkg::addr_t reg_off;
  logic           sel_msip;
  logic           sel_mtimecmp;
  logic           sel_mtime;
  logic           wr;

  assign reg_off      = (req_data_i.addr - soc_pkg::ClintBase) & WordMask;
  assign sel_msip     = reg_off == soc_pkg::MsipOffset;
  assign sel_mtimecmp = reg_off == soc_pkg::MtimecmpOffset;
  assign sel_mtime    = reg_off == soc_pkg::MtimeOffset;
  assign wr           = req_i & req_data_i.we;

  // ------------------------------
  // rtc tick, divide by two
  // ------------------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_q <= 1'b0;
    end else begin
      rtc_q <= ~rtc_q;
    end
  end

  // ------------------------------
  // timer and software registers
  // ------------------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1; // no timer irq until software sets it
      msip_q      <= 1'b0;
      timer_irq_o <= 1'b0;
    end else begin
      if (wr && sel_mtime) begin
        mtime_q <= soc_pkg::be_merge(mtime_q, req_data_i.wdata, req_data_i.be);
      end else if (rtc_q) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr && sel_mtimecmp) begin
        mtimecmp_q <= soc_pkg::be_merge(mtimecmp_q, req_data_i.wdata, req_data_i.be);
      end
      if (wr && sel_msip && req_data_i.be[0]) begin
        msip_q <= req_data_i.wdata[0];
      end
      timer_irq_o <= mtime_q >= mtimecmp_q;
    end
  end

  assign ipi_o = msip_q;

  // reads of unused offsets and all writes return zero
  always_ff @(posedge clk) begin
    if (req_i) begin
      if (req_data_i.we) begin
        rdata_o <= '0;
      end else if (sel_msip) begin
        rdata_o <= {{(soc_pkg::DataWidth-1){1'b0}}, msip_q};
      end else if (sel_mtimecmp) begin
        rdata_o <= mtimecmp_q;
      end else if (sel_mtime) begin
        rdata_o <= mtime_q;
      end else begin
        rdata_o <= '0;
      end
    end
  end

  // compare value at its reset default must never fire the timer
  a_no_irq_at_max_cmp: assert property (@(posedge clk) disable iff (!ndmreset_n)
    ((&mtimecmp_q) && !(&mtime_q)) |=> !timer_irq_o)
    else $error("timer irq raised with mtimecmp at all ones");

endmodule

`default_nettype wire

//--- hw/response_merge.sv
// Result stage. Registers the request strobe and the region select on
// the request edge, then picks the matching target's read data in the
// following cycle. An empty select answers with err and zero data.

`timescale 1ns/1ps
`default_nettype none

module response_merge (
  input  logic                 clk,
  input  logic                 ndmreset_n,
  input  logic                 req_i,
  input  soc_pkg::region_sel_t region_sel_i,
  input  soc_pkg::data_t       ram_rdata_i,
  input  soc_pkg::data_t       clint_rdata_i,
  output logic                 rsp_valid_o,
  output soc_pkg::bus_rsp_t    rsp_o
);

  logic                 valid_q;
  soc_pkg::region_sel_t sel_q;

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
      sel_q   <= '0;
    end else begin
      valid_q <= req_i;
      sel_q   <= region_sel_i;
    end
  end

  assign rsp_valid_o = valid_q;

  // targets already hold zero after a write
  always_comb begin
    rsp_o = '0;
    if (sel_q[0]) begin
      rsp_o.rdata = ram_rdata_i;
    end else if (sel_q[1]) begin
      rsp_o.rdata = clint_rdata_i;
    end else begin
      rsp_o.err = 1'b1; // unmapped
    end
  end

  a_rsp_follows_req: assert property (@(posedge clk) disable iff (!ndmreset_n)
    $rose(rsp_valid_o) |-> $past(req_i))
    else $error("response without a request in the previous cycle");

endmodule

`default_nettype wire

//--- hw/soc_pkg.sv
// Shared bus types, SoC address map and CLINT register offsets.
// Every RTL block refers to these by scoped name; the byte-enable
// merge helper is shared by the boot RAM and the CLINT registers.

`default_nettype none

package soc_pkg;

  // ------------------------------
  // bus widths
  // ------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned BeWidth   = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // ------------------------------
  // address map
  // ------------------------------
  localparam addr_t RomBase     = 32'h0001_0000; // boot RAM, length set by RomWords
  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h000C_0000;

  // CLINT offsets from ClintBase
  localparam addr_t MsipOffset     = 32'h0000_0000;
  localparam addr_t MtimecmpOffset = 32'h0000_4000;
  localparam addr_t MtimeOffset    = 32'h0000_BFF8;

  // one-hot, bit 0 boot RAM, bit 1 CLINT, zero means unmapped
  typedef logic [1:0] region_sel_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
    be_t   be;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // replace only the bytes whose enable is set
  function automatic data_t be_merge(data_t old_d, data_t new_d, be_t be);
    data_t res;
    res = old_d;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_d[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- hw/soc_top.sv
// Memory-mapped core of the SoC. A strobe bus master reaches the boot
// RAM and the CLINT through a combinational decoder, and each request
// is answered one cycle later by the result stage. The CLINT interrupt
// levels leave the top for the hart.

`timescale 1ns/1ps
`default_nettype none

module soc_top #(
  parameter int unsigned RomWords = 512 // boot RAM depth in 64-bit words
) (
  input  logic              clk,
  input  logic              ndmreset_n,
  input  logic              req_i,
  input  soc_pkg::bus_req_t req_data_i,
  output logic              rsp_valid_o,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  logic                 ram_req;
  logic                 clint_req;
  soc_pkg::region_sel_t region_sel;
  soc_pkg::data_t       ram_rdata;
  soc_pkg::data_t       clint_rdata;

  // ------------------------------
  // decode
  // ------------------------------
  address_decoder #(
    .RomWords ( RomWords )
  ) i_address_decoder (
    .req_i        ( req_i           ),
    .addr_i       ( req_data_i.addr ),
    .ram_req_o    ( ram_req         ),
    .clint_req_o  ( clint_req       ),
    .region_sel_o ( region_sel      )
  );

  // ------------------------------
  // targets
  // ------------------------------
  boot_ram #(
    .RomWords ( RomWords )
  ) i_boot_ram (
    .clk        ( clk        ),
    .req_i      ( ram_req    ),
    .req_data_i ( req_data_i ),
    .rdata_o    ( ram_rdata  )
  );

  clint i_clint (
    .clk         ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( clint_req   ),
    .req_data_i  ( req_data_i  ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // ------------------------------
  // result
  // ------------------------------
  response_merge i_response_merge (
    .clk           ( clk         ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_i         ( req_i       ),
    .region_sel_i  ( region_sel  ),
    .ram_rdata_i   ( ram_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .rsp_valid_o   ( rsp_valid_o ),
    .rsp_o         ( rsp_o       )
  );

endmodule

`default_nettype wire

//--- list.f
hw/soc_pkg.sv
hw/address_decoder.sv
hw/boot_ram.sv
hw/clint.sv
hw/response_merge.sv
hw/soc_top.sv
bench/tb_soc_top.sv
